// File: source/cpuPkg.sv
package cpuPkg;

    localparam int wordWidth     = 32;
    localparam int regCount      = 16;
    localparam int memDepth      = 512;
    localparam int regIndexWidth = $clog2(regCount);
    localparam int memIndexWidth = $clog2(memDepth);
    localparam int apbAddrWidth  = 12;
    localparam int opcodeWidth   = 5;
    localparam int dispWidth     = 19;

    localparam int opcodeLsb = 27;      // Opcode in 31:27
    localparam int raLsb     = 23;      // Ra in 26:23
    localparam int rbLsb     = 19;      // Rb in 22:19, C below it

    typedef logic [wordWidth-1:0]     word_t;
    typedef logic [regIndexWidth-1:0] regIndex_t;
    typedef logic [memIndexWidth-1:0] memIndex_t;
    typedef logic [apbAddrWidth-1:0]  apbAddr_t;
    typedef logic [dispWidth-1:0]     disp_t;

    typedef enum logic [opcodeWidth-1:0] {
        opLd   = 5'd0,
        opLdi  = 5'd1,
        opHalt = 5'd31                  // Unknown opcodes also halt
    } opcode_t;

    typedef enum logic [3:0] {
        sIdle,
        sT0, sT1, sT2, sT3, sT4,
        sT5, sT6, sT7, sT8, sT9,
        sHalted
    } seqState_t;

    typedef struct packed {
        logic pcOut;
        logic zOut;
        logic mdrOut;
        logic cOut;
        logic baOut;                    // Register onto bus, R0 reads as zero
        logic marIn;
        logic mdrIn;
        logic irIn;
        logic yIn;
        logic zIn;
        logic pcIn;
        logic rIn;
        logic gra;
        logic grb;
        logic incPc;
        logic add;
        logic memRead;
    } controlWord_t;

    localparam apbAddr_t offCtrl    = 12'h000;
    localparam apbAddr_t offStartPc = 12'h004;
    localparam apbAddr_t offStatus  = 12'h008;
    localparam apbAddr_t offCount   = 12'h00C;
    localparam apbAddr_t offRegBase = 12'h040;  // Sixteen words
    localparam apbAddr_t offMemBase = 12'h800;  // 512 words up to the top of the map

endpackage

// File: source/registerFile.sv
`timescale 1ns/1ps

module registerFile import cpuPkg::*; (
    input  logic      clock,
    input  logic      rst,
    input  regIndex_t sel,
    input  logic      baOut,
    input  logic      rIn,
    input  word_t     wdata,
    output word_t     rdata,
    input  regIndex_t peekIndex,
    output word_t     peekData
);

    word_t regs [regCount];

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (rIn) begin
            regs[sel] <= wdata;
        end
    end

    // Base address reads of R0 give zero
    assign rdata = (baOut && sel == '0) ? '0 : regs[sel];

    assign peekData = regs[peekIndex];      // APB readback

endmodule

// File: source/wordMemory.sv
`timescale 1ns/1ps

module wordMemory import cpuPkg::*; (
    input  logic      clock,
    input  memIndex_t aAddr,
    input  logic      aRead,
    output word_t     aRdata,
    input  memIndex_t bAddr,
    input  logic      bWrite,
    input  word_t     bWdata,
    output word_t     bRdata
);

    word_t mem [memDepth];

    always_ff @(posedge clock) begin        // Datapath port, read only
        if (aRead) begin
            aRdata <= mem[aAddr];
        end
    end

    always_ff @(posedge clock) begin        // APB port
        if (bWrite) begin
            mem[bAddr] <= bWdata;
        end
        bRdata <= mem[bAddr];
    end

endmodule

// File: source/busDatapath.sv
`timescale 1ns/1ps

module busDatapath import cpuPkg::*; (
    input  logic         clock,
    input  logic         rst,
    input  controlWord_t ctrl,
    input  logic         startPulse,
    input  word_t        startPc,
    output word_t        busValue,
    output word_t        ir,
    output regIndex_t    regSelect,
    output memIndex_t    memAddr,
    input  word_t        memRdata,
    input  word_t        regRdata
);

    word_t     pc;
    memIndex_t mar;
    word_t     mdr;
    word_t     yReg;
    word_t     zReg;
    word_t     cExt;
    word_t     aluOut;

    assign cExt = {{(wordWidth - dispWidth){ir[dispWidth-1]}}, ir[dispWidth-1:0]};

    always_comb begin
        case (1'b1)
            ctrl.pcOut:  busValue = pc;
            ctrl.zOut:   busValue = zReg;
            ctrl.mdrOut: busValue = mdr;
            ctrl.cOut:   busValue = cExt;
            ctrl.baOut:  busValue = regRdata;
            default:     busValue = '0;      // Bus floats low
        endcase
    end

    always_comb begin
        if (ctrl.add) begin
            aluOut = yReg + busValue;
        end else if (ctrl.incPc) begin
            aluOut = pc + word_t'(1);
        end else begin
            aluOut = busValue;
        end
    end

    assign regSelect = ctrl.gra ? ir[raLsb +: regIndexWidth] :
                       ctrl.grb ? ir[rbLsb +: regIndexWidth] : '0;

    always_ff @(posedge clock) begin
        if (rst) begin
            pc <= '0;
            ir <= '0;
        end else begin
            if (startPulse) begin
                pc <= startPc;              // New run
            end else if (ctrl.pcIn) begin
                pc <= busValue;
            end
            if (ctrl.irIn) begin
                ir <= busValue;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (ctrl.marIn) begin
            mar <= busValue[memIndexWidth-1:0];
        end
        if (ctrl.mdrIn) begin
            mdr <= memRdata;                // Read data from port A
        end
        if (ctrl.yIn) begin
            yReg <= busValue;
        end
        if (ctrl.zIn) begin
            zReg <= aluOut;
        end
    end

    assign memAddr = mar;

endmodule

// File: source/controlSequencer.sv
`timescale 1ns/1ps

module controlSequencer import cpuPkg::*; (
    input  logic         clock,
    input  logic         rst,
    input  logic         startPulse,
    input  word_t        ir,
    output controlWord_t ctrl,
    output logic         running,
    output logic         halted,
    output word_t        instrCount
);

    seqState_t state;
    seqState_t nextState;
    opcode_t   opcode;
    logic      isLoad;
    logic      instrDone;

    assign opcode    = opcode_t'(ir[opcodeLsb +: opcodeWidth]);
    assign isLoad    = (opcode == opLd) || (opcode == opLdi);
    assign instrDone = (state == sT6 && opcode == opLdi) || state == sT9;

    always_comb begin
        nextState = state;
        case (state)
            sIdle, sHalted: nextState = startPulse ? sT0 : state;
            sT0:     nextState = sT1;
            sT1:     nextState = sT2;
            sT2:     nextState = sT3;
            sT3:     nextState = sT4;
            sT4:     nextState = isLoad ? sT5 : sHalted;   // Decode
            sT5:     nextState = sT6;
            sT6:     nextState = (opcode == opLdi) ? sT0 : sT7;
            sT7:     nextState = sT8;
            sT8:     nextState = sT9;
            sT9:     nextState = sT0;
            default: nextState = sIdle;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= sIdle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        ctrl = '0;
        case (state)
            sT0: begin                      // MAR gets PC, Z gets PC plus one
                ctrl.pcOut = 1'b1;
                ctrl.marIn = 1'b1;
                ctrl.incPc = 1'b1;
                ctrl.zIn   = 1'b1;
            end
            sT1: begin
                ctrl.zOut    = 1'b1;
                ctrl.pcIn    = 1'b1;
                ctrl.memRead = 1'b1;
            end
            sT2: ctrl.mdrIn = 1'b1;
            sT3: begin
                ctrl.mdrOut = 1'b1;
                ctrl.irIn   = 1'b1;
            end
            sT4: begin                      // Base from Rb
                ctrl.grb   = 1'b1;
                ctrl.baOut = 1'b1;
                ctrl.yIn   = 1'b1;
            end
            sT5: begin
                ctrl.cOut = 1'b1;
                ctrl.add  = 1'b1;
                ctrl.zIn  = 1'b1;
            end
            sT6: begin
                ctrl.zOut = 1'b1;
                if (opcode == opLdi) begin
                    ctrl.gra = 1'b1;
                    ctrl.rIn = 1'b1;
                end else begin
                    ctrl.marIn = 1'b1;      // Effective address
                end
            end
            sT7: ctrl.memRead = 1'b1;
            sT8: ctrl.mdrIn = 1'b1;
            sT9: begin
                ctrl.mdrOut = 1'b1;
                ctrl.gra    = 1'b1;
                ctrl.rIn    = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst || startPulse) begin
            instrCount <= '0;
        end else if (instrDone) begin
            instrCount <= instrCount + word_t'(1);
        end
    end

    always_ff @(posedge clock) begin
        if (rst || startPulse) begin
            halted <= 1'b0;
        end else if (state == sT4 && !isLoad) begin
            halted <= 1'b1;                 // Halt decoded
        end
    end

    assign running = state != sIdle && state != sHalted;

endmodule

// File: source/apbControlRegs.sv
`timescale 1ns/1ps

module apbControlRegs import cpuPkg::*; (
    input  logic      clock,
    input  logic      rst,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apbAddr_t  paddr,
    input  word_t     pwdata,
    output word_t     prdata,
    output logic      pready,
    output logic      pslverr,
    output logic      startPulse,
    output word_t     startPc,
    input  logic      running,
    input  logic      halted,
    input  word_t     instrCount,
    output regIndex_t peekIndex,
    input  word_t     peekData,
    output memIndex_t memAddr,
    output logic      memWrite,
    output word_t     memWdata,
    input  word_t     memRdata
);

    logic  hitCtrl;
    logic  hitStartPc;
    logic  hitStatus;
    logic  hitCount;
    logic  hitReg;
    logic  hitMem;
    logic  accessPhase;
    logic  waitDone;                        // Memory read wait state spent
    logic  accessErr;
    logic  accept;
    word_t readData;

    assign hitCtrl    = paddr == offCtrl;
    assign hitStartPc = paddr == offStartPc;
    assign hitStatus  = paddr == offStatus;
    assign hitCount   = paddr == offCount;
    assign hitReg     = paddr[1:0] == 2'b00 && paddr >= offRegBase
                        && paddr < offRegBase + apbAddr_t'(4 * regCount);
    assign hitMem     = paddr[1:0] == 2'b00 && paddr >= offMemBase;

    assign peekIndex = paddr[2 +: regIndexWidth];
    assign memAddr   = paddr[2 +: memIndexWidth];
    assign memWdata  = pwdata;

    assign accessPhase = psel && penable;
    assign pready      = !(accessPhase && hitMem && !pwrite && !waitDone);

    assign accessErr = (pwrite && (hitStatus || hitCount || hitReg))
                       || ((hitReg || hitMem) && running)
                       || !(hitCtrl || hitStartPc || hitStatus || hitCount || hitReg || hitMem);

    assign pslverr  = accessPhase && pready && accessErr;
    assign accept   = accessPhase && pready && !accessErr;
    assign memWrite = accept && pwrite && hitMem;

    always_comb begin
        readData = '0;
        case (1'b1)
            hitStartPc: readData = startPc;
            hitStatus:  readData = word_t'({halted, running});
            hitCount:   readData = instrCount;
            hitReg:     readData = peekData;
            hitMem:     readData = memRdata;
            default:    readData = '0;      // Control reads as zero
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            startPulse <= 1'b0;
            startPc    <= '0;
            waitDone   <= 1'b0;
            prdata     <= '0;
        end else begin
            startPulse <= accept && pwrite && hitCtrl && pwdata[0] && !running;
            waitDone   <= accessPhase && !pready;
            if (accept && pwrite && hitStartPc) begin
                startPc <= pwdata;
            end
            // Capture in setup, or in the wait state for memory reads
            if (psel && !pwrite && (!penable || !pready)) begin
                prdata <= readData;
            end
        end
    end

endmodule

// File: source/loadCore.sv
`timescale 1ns/1ps

module loadCore import cpuPkg::*; (
    input  logic     clock,
    input  logic     rst,
    input  logic     psel,
    input  logic     penable,
    input  logic     pwrite,
    input  apbAddr_t paddr,
    input  word_t    pwdata,
    output word_t    prdata,
    output logic     pready,
    output logic     pslverr
);

    logic         startPulse;
    word_t        startPc;
    logic         running;
    logic         halted;
    word_t        instrCount;
    controlWord_t ctrl;
    word_t        ir;
    word_t        busValue;
    regIndex_t    regSelect;
    word_t        regRdata;
    memIndex_t    dpMemAddr;
    word_t        dpMemRdata;
    regIndex_t    peekIndex;
    word_t        peekData;
    memIndex_t    apbMemAddr;
    logic         apbMemWrite;
    word_t        apbMemWdata;
    word_t        apbMemRdata;

    apbControlRegs apbRegs (
        .clock(clock), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .startPulse(startPulse), .startPc(startPc),
        .running(running), .halted(halted), .instrCount(instrCount),
        .peekIndex(peekIndex), .peekData(peekData),
        .memAddr(apbMemAddr), .memWrite(apbMemWrite),
        .memWdata(apbMemWdata), .memRdata(apbMemRdata)
    );

    controlSequencer sequencer (
        .clock(clock), .rst(rst), .startPulse(startPulse), .ir(ir), .ctrl(ctrl),
        .running(running), .halted(halted), .instrCount(instrCount)
    );

    busDatapath datapath (
        .clock(clock), .rst(rst), .ctrl(ctrl),
        .startPulse(startPulse), .startPc(startPc),
        .busValue(busValue), .ir(ir), .regSelect(regSelect),
        .memAddr(dpMemAddr), .memRdata(dpMemRdata), .regRdata(regRdata)
    );

    registerFile regFile (
        .clock(clock), .rst(rst), .sel(regSelect), .baOut(ctrl.baOut),
        .rIn(ctrl.rIn), .wdata(busValue), .rdata(regRdata),
        .peekIndex(peekIndex), .peekData(peekData)
    );

    wordMemory memory (
        .clock(clock),
        .aAddr(dpMemAddr), .aRead(ctrl.memRead), .aRdata(dpMemRdata),
        .bAddr(apbMemAddr), .bWrite(apbMemWrite),
        .bWdata(apbMemWdata), .bRdata(apbMemRdata)
    );

endmodule

// File: test/loadCore_properties.sv
`timescale 1ns/1ps

module loadCore_properties import cpuPkg::*; (
    input logic         clock,
    input logic         rst,
    input controlWord_t ctrl,
    input logic         psel,
    input logic         penable,
    input logic         pready,
    input logic         pwrite,
    input word_t        prdata,
    input logic         running,
    input logic         halted
);

    busOneSource: assert property (@(posedge clock) disable iff (rst)
        $onehot0({ctrl.pcOut, ctrl.zOut, ctrl.mdrOut, ctrl.cOut, ctrl.baOut}))
        else $error("more than one bus source active");

    enableNeedsSelect: assert property (@(posedge clock) disable iff (rst)
        penable |-> psel)
        else $error("penable high without psel");

    readDataHeld: assert property (@(posedge clock) disable iff (rst)
        psel && penable && pready && !pwrite |=> $stable(prdata))
        else $error("prdata changed after a completed read");

    runOrHalt: assert property (@(posedge clock) disable iff (rst)
        !(running && halted))
        else $error("running and halted high together");

endmodule

// File: test/loadCoreTb.sv
`timescale 1ns/1ps

module loadCoreTb import cpuPkg::*; ();

    localparam int resetCycles    = 8;
    localparam int randomLength   = 64;
    localparam int directedLength = 16;      // All directed programs together
    localparam int cyclesPerInstr = 10;      // ld is the longest path
    localparam int cyclesPerXfer  = 4;       // Setup, access, wait state, idle
    // Memory fill, program loads, register readbacks and status polls
    localparam int xferCount      = memDepth + 3 * randomLength + 8 * regCount + 100;
    localparam int timeoutCycles  = resetCycles + xferCount * cyclesPerXfer
                                    + (randomLength + directedLength) * cyclesPerInstr + 1000;

    logic     clock;
    logic     rst;
    logic     psel;
    logic     penable;
    logic     pwrite;
    apbAddr_t paddr;
    word_t    pwdata;
    word_t    prdata;
    logic     pready;
    logic     pslverr;

    word_t refMem [memDepth];                // Reference model state
    word_t refRegs [regCount];
    word_t progWords [$];
    word_t lfsrState = 32'ha701a1da;
    int    cycleCount = 0;

    loadCore dut_i (
        .clock(clock), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    bind loadCore loadCore_properties props (
        .clock(clock), .rst(rst), .ctrl(ctrl),
        .psel(psel), .penable(penable), .pready(pready), .pwrite(pwrite),
        .prdata(prdata), .running(running), .halted(halted)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == timeoutCycles) begin
            reportFailure("Timeout: the core or the bus did not finish in time");
        end
    end

    task automatic reportFailure(string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkWord(string name, word_t expected, word_t actual);
        if (actual !== expected) begin
            reportFailure($sformatf("Error %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic checkFlag(string name, logic expected, logic actual);
        if (actual !== expected) begin
            reportFailure($sformatf("Error %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    // Taps 32, 22, 2, 1
    function automatic word_t lfsr32(word_t state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic word_t randomBits(int count);
        word_t value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsr32(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
        return value;
    endfunction

    function automatic word_t encode(logic [4:0] op, regIndex_t ra, regIndex_t rb, disp_t c);
        return {op, ra, rb, c};
    endfunction

    function automatic apbAddr_t regWordAddr(int index);
        return offRegBase + apbAddr_t'(index * 4);
    endfunction

    function automatic apbAddr_t memWordAddr(int index);
        return offMemBase + apbAddr_t'(index * 4);
    endfunction

    // Executes from startPc until a halt, returns the number of loads
    function automatic int runProgram(word_t startPc);
        word_t      pc;
        word_t      instr;
        word_t      base;
        word_t      addr;
        word_t      cExt;
        logic [4:0] op;
        regIndex_t  ra;
        regIndex_t  rb;
        int         count;
        int         steps;
        logic       done;
        pc = startPc;
        count = 0;
        steps = 0;
        done = 1'b0;
        while (!done && steps < 4096) begin
            instr = refMem[pc[memIndexWidth-1:0]];
            pc = pc + 1;
            op = instr[31:27];
            ra = instr[26:23];
            rb = instr[22:19];
            cExt = {{(wordWidth - dispWidth){instr[18]}}, instr[18:0]};
            base = (rb == 4'd0) ? 32'd0 : refRegs[rb];      // R0 base is zero
            addr = base + cExt;
            if (op == 5'd1) begin
                refRegs[ra] = addr;
                count++;
            end else if (op == 5'd0) begin
                refRegs[ra] = refMem[addr[memIndexWidth-1:0]];
                count++;
            end else begin
                done = 1'b1;                                // halt and unknown opcodes
            end
            steps++;
        end
        return count;
    endfunction

    task automatic apbTransfer(logic write, apbAddr_t addr, word_t wdata,
                               output word_t rdata, output logic err);
        logic memRead;
        memRead = !write && addr >= offMemBase;      // Memory reads take one wait state
        @(posedge clock);
        #1;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = write;
        paddr = addr;
        pwdata = wdata;
        @(posedge clock);
        #1;
        penable = 1'b1;
        @(negedge clock);
        checkFlag($sformatf("pready at %h", addr), !memRead, pready);
        if (memRead) begin
            @(negedge clock);
            checkFlag($sformatf("pready after wait at %h", addr), 1'b1, pready);
        end
        rdata = prdata;
        err = pslverr;
        @(posedge clock);
        #1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic apbWrite(apbAddr_t addr, word_t data, output logic err);
        word_t unused;
        apbTransfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apbRead(apbAddr_t addr, output word_t data, output logic err);
        apbTransfer(1'b0, addr, 32'd0, data, err);
    endtask

    task automatic writeOk(apbAddr_t addr, word_t data, string name);
        logic err;
        apbWrite(addr, data, err);
        checkFlag({name, " pslverr"}, 1'b0, err);
    endtask

    task automatic readOk(apbAddr_t addr, string name, output word_t data);
        logic err;
        apbRead(addr, data, err);
        checkFlag({name, " pslverr"}, 1'b0, err);
    endtask

    task automatic writeMemory(int index, word_t value);
        refMem[index] = value;
        writeOk(memWordAddr(index), value, $sformatf("memory write %0d", index));
    endtask

    task automatic loadProgram(int base);
        foreach (progWords[i]) begin
            writeMemory(base + i, progWords[i]);
        end
    endtask

    task automatic startCore(word_t pc);
        writeOk(offStartPc, pc, "start pc write");
        writeOk(offCtrl, 32'd1, "start write");
    endtask

    task automatic waitForHalt();
        word_t status;
        status = '0;
        while (!status[1]) begin
            readOk(offStatus, "status poll", status);
        end
    endtask

    task automatic checkRegister(string name, int index, word_t expected);
        word_t value;
        readOk(regWordAddr(index), name, value);
        checkWord(name, expected, value);
    endtask

    task automatic checkRegisters(string name);
        for (int i = 0; i < regCount; i++) begin
            checkRegister($sformatf("%s R%0d", name, i), i, refRegs[i]);
        end
    endtask

    task automatic finishRun(string name, int expectedCount);
        word_t value;
        waitForHalt();
        readOk(offCount, {name, " count"}, value);
        checkWord({name, " count"}, word_t'(expectedCount), value);
        readOk(offStatus, {name, " status"}, value);
        checkWord({name, " status"}, 32'd2, value);  // Halted, not running
        checkRegisters(name);
    endtask

    initial begin
        word_t   data;
        logic    err;
        int      count;
        opcode_t op;
        disp_t   c;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        rst = 1'b1;
        for (int i = 0; i < regCount; i++) begin
            refRegs[i] = '0;
        end
        repeat (resetCycles) @(posedge clock);
        #1;
        rst = 1'b0;

        readOk(offStatus, "status after reset", data);
        checkWord("status after reset", 32'd0, data);
        readOk(offCount, "count after reset", data);
        checkWord("count after reset", 32'd0, data);
        checkRegisters("after reset");

        for (int a = 0; a < memDepth; a++) begin   // Random data everywhere
            writeMemory(a, randomBits(32));
        end
        for (int a = 0; a < memDepth; a += 73) begin
            readOk(memWordAddr(a), "memory readback", data);
            checkWord($sformatf("memory readback %0d", a), refMem[a], data);
        end

        // ldi with base R0, both signs of C
        c = disp_t'(randomBits(dispWidth));
        progWords = {};
        progWords.push_back(encode(opLdi, 4'd1, 4'd0, 19'd5));
        progWords.push_back(encode(opLdi, 4'd2, 4'd0, disp_t'(-3)));
        progWords.push_back(encode(opLdi, 4'd3, 4'd0, 19'h3FFFF));
        progWords.push_back(encode(opLdi, 4'd4, 4'd0, 19'h40000));
        progWords.push_back(encode(opLdi, 4'd5, 4'd0, c));
        progWords.push_back(encode(opHalt, 4'd0, 4'd0, 19'd0));
        loadProgram(16);
        void'(runProgram(32'd16));
        startCore(32'd16);
        finishRun("ldi base zero", 5);
        checkRegister("ldi positive", 1, 32'd5);
        checkRegister("ldi negative", 2, 32'hFFFF_FFFD);
        checkRegister("ldi largest C", 3, 32'h0003_FFFF);
        checkRegister("ldi smallest C", 4, 32'hFFFC_0000);
        checkRegister("ldi random C", 5, {{(wordWidth - dispWidth){c[dispWidth-1]}}, c});

        // ldi with a register base from earlier results
        progWords = {};
        progWords.push_back(encode(opLdi, 4'd6, 4'd1, 19'd100));
        progWords.push_back(encode(opLdi, 4'd7, 4'd2, disp_t'(-10)));
        progWords.push_back(encode(opLdi, 4'd8, 4'd6, disp_t'(-105)));
        progWords.push_back(encode(opLdi, 4'd0, 4'd1, 19'd7));
        progWords.push_back(encode(opLdi, 4'd9, 4'd0, 19'd1));  // R0 base still zero
        progWords.push_back(encode(opHalt, 4'd0, 4'd0, 19'd0));
        loadProgram(48);
        void'(runProgram(32'd48));
        startCore(32'd48);
        finishRun("ldi register base", 5);
        checkRegister("ldi base R1", 6, 32'd105);
        checkRegister("ldi base R2", 7, 32'hFFFF_FFF3);
        checkRegister("ldi to zero", 8, 32'd0);
        checkRegister("ldi into R0", 0, 32'd12);
        checkRegister("ldi base R0 after write", 9, 32'd1);

        // A halt at the start PC counts nothing
        progWords = {};
        progWords.push_back(encode(opHalt, 4'd0, 4'd0, 19'd0));
        loadProgram(80);
        void'(runProgram(32'd80));
        startCore(32'd80);
        finishRun("halt only", 0);

        // Unknown opcode stops like halt
        progWords = {};
        progWords.push_back(encode(opLdi, 4'd10, 4'd0, 19'h1234));
        progWords.push_back(encode(5'd7, 4'd0, 4'd0, 19'd0));
        loadProgram(84);
        void'(runProgram(32'd84));
        startCore(32'd84);
        finishRun("unknown opcode", 1);
        checkRegister("ldi before unknown opcode", 10, 32'h0000_1234);

        // Random ld and ldi mix
        progWords = {};
        for (int i = 0; i < randomLength; i++) begin
            data = randomBits(1);
            op = data[0] ? opLdi : opLd;
            data = randomBits(8);
            c = disp_t'(randomBits(dispWidth));
            progWords.push_back(encode(op, data[7:4], data[3:0], c));
        end
        progWords.push_back(encode(opHalt, 4'd0, 4'd0, 19'd0));
        loadProgram(256);
        count = runProgram(32'd256);
        startCore(32'd256);
        readOk(offStatus, "status while running", data);
        checkWord("status while running", 32'd1, data);
        apbRead(memWordAddr(5), data, err);
        checkFlag("memory read while running", 1'b1, err);
        apbWrite(memWordAddr(5), ~refMem[5], err);
        checkFlag("memory write while running", 1'b1, err);
        apbRead(regWordAddr(3), data, err);
        checkFlag("register read while running", 1'b1, err);
        finishRun("random program", count);
        readOk(memWordAddr(5), "memory after refused write", data);
        checkWord("memory after refused write", refMem[5], data);

        // Refused accesses leave state alone
        apbWrite(offStatus, 32'hFFFF_FFFF, err);
        checkFlag("status write", 1'b1, err);
        readOk(offStatus, "status after refused write", data);
        checkWord("status after refused write", 32'd2, data);
        apbWrite(offCount, 32'd0, err);
        checkFlag("count write", 1'b1, err);
        readOk(offCount, "count after refused write", data);
        checkWord("count after refused write", word_t'(randomLength), data);
        apbWrite(12'h100, 32'h55, err);
        checkFlag("unmapped write", 1'b1, err);
        readOk(offStartPc, "start pc after unmapped write", data);
        checkWord("start pc after unmapped write", 32'd256, data);
        apbRead(12'h010, data, err);
        checkFlag("unmapped read", 1'b1, err);
        apbWrite(regWordAddr(1), 32'hDEAD_BEEF, err);
        checkFlag("register window write", 1'b1, err);
        checkRegister("register after refused write", 1, refRegs[1]);

        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: sim.f
source/cpuPkg.sv
source/registerFile.sv
source/wordMemory.sv
source/busDatapath.sv
source/controlSequencer.sv
source/apbControlRegs.sv
source/loadCore.sv
test/loadCore_properties.sv
test/loadCoreTb.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sim.f --top-module loadCoreTb -Mdir obj_dir -o loadCoreSim

run: compile
	./obj_dir/loadCoreSim > sim.log 2>&1 || true
	cat sim.log
	! grep -q "ERRORS FOUND" sim.log
	grep -q "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log
